// File: dv/rx_props.sv
// req/ack rules of the byte output, bound into rx_top
// fail_cnt counts failed properties for the testbench summary
`default_nettype none

module rx_props (
    input logic       clk,
    input logic       rst_n,
    input logic       out_req,
    input logic       out_ack,
    input logic [7:0] out_data,
    input logic [3:0] out_bits,
    input logic       out_last
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;

    // req still low after the first active edge out of reset
    req_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !out_req)
        else begin
            $error("out_req high in the first cycle after reset");
            fail_cnt++;
        end

    // req rises only from a cycle where ack was seen low
    req_rise_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> !$past(out_ack))
        else begin
            $error("out_req rose while out_ack was high");
            fail_cnt++;
        end

    // payload frozen for the whole handshake
    payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req && $past(out_req)) |-> ($stable(out_data) && $stable(out_bits) &&
                                         $stable(out_last)))
        else begin
            $error("out_data, out_bits or out_last changed while out_req was high");
            fail_cnt++;
        end

    // phase 3 follows phase 2
    req_fall_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_req) |-> $past(out_ack))
        else begin
            $error("out_req fell without out_ack");
            fail_cnt++;
        end

endmodule

bind rx_top rx_props props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data),
    .out_bits (out_bits),
    .out_last (out_last)
);

`default_nettype wire

// File: dv/rx_tb.sv
// testbench for the type A receive path
// sends frames bit by bit, models the expected transfers with its own CRC_A
// and answers the req/ack port with a randomly delayed consumer
`default_nettype none

module rx_tb
    import rx_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int fifo_depth   = 8;
    localparam int clk_period   = 10;
    // six checked frames plus one sent during a delivery
    localparam int n_frames     = 7;
    // overflow frame with a slow consumer is the longest
    localparam int frame_cycles = 300;

    logic          clk;
    logic          rst_n;
    logic          soc;
    logic          eoc;
    logic          bit_valid;
    logic          bit_data;
    logic          line_error;
    logic          out_ack;
    logic          out_req;
    logic [7:0]    out_data;
    logic [3:0]    out_bits;
    logic          out_last;
    frame_status_e out_status;

    integer        seed = 32'h8df7_decc;
    // one entry per expected transfer: {status, last, bits, data}
    logic [14:0]   exp_q[$];
    // bytes of the frame about to be sent, first on air first
    logic [7:0]    frame_q[$];
    int            frames_sent = 0;
    int            frames_done = 0;
    int            xfer_cnt = 0;
    int            err_cnt = 0;
    // slow consumer, lets a second frame arrive mid delivery
    logic          hold_ack = 1'b0;

    rx_top #(
        .fifo_depth (fifo_depth)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .soc        (soc),
        .eoc        (eoc),
        .bit_valid  (bit_valid),
        .bit_data   (bit_data),
        .line_error (line_error),
        .out_ack    (out_ack),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_bits   (out_bits),
        .out_last   (out_last),
        .out_status (out_status)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // CRC_A one bit at a time, reflected, no final xor
    function automatic logic [15:0] crc_step(input logic [15:0] crc_in, input logic [7:0] d);
        logic [15:0] c;
        logic        fb;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ d[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ 16'h8408;
            end
        end
        return c;
    endfunction

    // CRC over the frame so far, low byte first on air
    task automatic append_crc();
        logic [15:0] crc;
        crc = 16'h6363;
        foreach (frame_q[i]) begin
            crc = crc_step(crc, frame_q[i]);
        end
        frame_q.push_back(crc[7:0]);
        frame_q.push_back(crc[15:8]);
    endtask

    task automatic random_frame(input int n);
        frame_q.delete();
        repeat (n) begin
            frame_q.push_back(8'($random(seed)));
        end
    endtask

    // one clock of line inputs, set just after the edge
    task automatic drive_cycle(input logic s, input logic bv, input logic bd, input logic le,
                               input logic e);
        @(posedge clk);
        #1;
        soc        = s;
        bit_valid  = bv;
        bit_data   = bd;
        line_error = le;
        eoc        = e;
    endtask

    // tail_bits > 0 makes the last byte partial, err_after >= 0 puts a line error
    // inside that byte, modeled = 0 sends a frame that must be ignored
    task automatic send_frame(input int tail_bits, input int err_after, input bit modeled);
        int            n_whole;
        int            n_keep;
        int            nb;
        logic [15:0]   crc;
        logic [7:0]    cur;
        logic [3:0]    bits;
        frame_status_e st;
        n_whole = (tail_bits > 0) ? frame_q.size() - 1 : frame_q.size();
        crc = 16'h6363;
        for (int i = 0; i < n_whole; i++) begin
            crc = crc_step(crc, frame_q[i]);
        end
        // whole bytes before an error survive, a full FIFO keeps fifo_depth entries
        n_keep = (err_after >= 0) ? err_after : frame_q.size();
        if ((err_after >= 0) || (n_keep > fifo_depth)) begin
            st = frame_line_err;
        end else if ((n_whole < 3) || (tail_bits > 0)) begin
            st = frame_no_crc;
        end else if (crc == 16'h0000) begin
            st = frame_ok;
        end else begin
            st = frame_crc_err;
        end
        if (n_keep > fifo_depth) begin
            n_keep = fifo_depth;
        end
        if (modeled) begin
            frames_sent++;
            // empty frame still gives one zero-bit transfer
            if (n_keep == 0) begin
                exp_q.push_back({st, 1'b1, 4'd0, 8'h00});
            end
            for (int i = 0; i < n_keep; i++) begin
                bits = ((tail_bits > 0) && (i == frame_q.size() - 1)) ? 4'(tail_bits) : 4'd8;
                cur  = frame_q[i] & (8'hff >> (4'd8 - bits));
                exp_q.push_back({st, (i == n_keep - 1), bits, cur});
            end
        end
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < frame_q.size(); i++) begin
            cur = frame_q[i];
            nb  = ((tail_bits > 0) && (i == frame_q.size() - 1)) ? tail_bits : 8;
            for (int b = 0; b < nb; b++) begin
                if ((i == err_after) && (b == 3)) begin
                    drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
                end
                drive_cycle(1'b0, 1'b1, cur[b], 1'b0, 1'b0);
            end
        end
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic wait_delivered();
        while (frames_done != frames_sent) begin
            @(posedge clk);
            #1;
        end
    endtask

    // compare the held transfer with the oldest expected entry
    task automatic check_transfer();
        logic [14:0] e;
        xfer_cnt++;
        if (exp_q.size() == 0) begin
            $display("a transfer arrived while no frame was expected");
            err_cnt++;
        end else begin
            e = exp_q.pop_front();
            assert (out_data == e[7:0]) else begin
                $display("error out_data got %h expected %h", out_data, e[7:0]);
                err_cnt++;
            end
            assert (out_bits == e[11:8]) else begin
                $display("error out_bits got %h expected %h", out_bits, e[11:8]);
                err_cnt++;
            end
            assert (out_last == e[12]) else begin
                $display("error out_last got %h expected %h", out_last, e[12]);
                err_cnt++;
            end
            // status only counts on the last byte
            if (e[12]) begin
                assert (out_status == e[14:13]) else begin
                    $display("error out_status got %h expected %h", out_status, e[14:13]);
                    err_cnt++;
                end
            end
        end
    endtask

    initial begin : consumer
        int unsigned wait_cyc;
        logic        got_last;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !out_ack) begin
                wait_cyc = hold_ack ? 32'd12 : ($unsigned($random(seed)) % 32'd4);
                repeat (wait_cyc) begin
                    @(posedge clk);
                    #1;
                end
                got_last = out_last;
                check_transfer();
                out_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (out_req);
                out_ack = 1'b0;
                if (got_last) begin
                    frames_done++;
                end
            end
        end
    end

    initial begin : watchdog
        #(n_frames * frame_cycles * clk_period);
        $display("timeout while waiting for the frames to be delivered");
        $display("Finished with errors");
        $finish;
    end

    initial begin : stimulus
        soc        = 1'b0;
        eoc        = 1'b0;
        bit_valid  = 1'b0;
        bit_data   = 1'b0;
        line_error = 1'b0;
        rst_n      = 1'b0;
        repeat (5) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        // HLTA with its CRC_A
        frame_q = '{8'h50, 8'h00};
        append_crc();
        send_frame(0, -1, 1'b1);
        wait_delivered();
        // REQA, 7 bits
        frame_q = '{8'h26};
        send_frame(7, -1, 1'b1);
        wait_delivered();
        // RATS with one CRC bit flipped
        frame_q = '{8'he0, 8'h80};
        append_crc();
        frame_q[3] = frame_q[3] ^ 8'h01;
        send_frame(0, -1, 1'b1);
        wait_delivered();
        // line error inside the third byte
        random_frame(5);
        send_frame(0, 2, 1'b1);
        wait_delivered();
        // overrun with a slow consumer, then a frame that lands in the delivery
        hold_ack = 1'b1;
        random_frame(12);
        send_frame(0, -1, 1'b1);
        frame_q = '{8'h52, 8'h11};
        send_frame(0, -1, 1'b0);
        wait_delivered();
        hold_ack = 1'b0;
        // soc and eoc with no bits
        frame_q.delete();
        send_frame(0, -1, 1'b1);
        wait_delivered();
        repeat (5) begin
            @(posedge clk);
        end
        $display("transfers %0d, transfer errors %0d, assertion failures %0d, left over %0d",
                 xfer_cnt, err_cnt, dut_i.props_i.fail_cnt, exp_q.size());
        if ((err_cnt == 0) && (dut_i.props_i.fail_cnt == 0) && (exp_q.size() == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/rx_pkg.sv
src/bit_deserialiser.sv
src/crc_a_checker.sv
src/rx_byte_fifo.sv
src/rx_frame_ctrl.sv
src/rx_top.sv
dv/rx_props.sv
dv/rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the receive path testbench with Verilator, runs it, checks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rx_tb -f filelist.f -o rx_sim \
    || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/rx_sim +verilator+error+limit+1000)"
echo "$sim_out"
grep -q "^Finished with no errors$" <<< "$sim_out" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/bit_deserialiser.sv
// packs decoded bits into bytes, lsb first
// a partial byte is flushed at eoc with its bit count
`default_nettype none

module bit_deserialiser (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       soc,
    input  logic       eoc,
    input  logic       bit_valid,
    input  logic       bit_data,
    input  logic       line_error,
    input  logic       enable,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic [3:0] byte_bits,
    output logic       byte_last,
    output logic       frame_end,
    output logic       seen_error
);

    // bits held in byte_data so far, wraps at eight
    logic [2:0] bit_cnt;
    logic       take_bit;
    logic       take_eoc;
    logic       take_err;

    // nothing from the line counts unless the controller is receiving
    assign take_bit = enable && bit_valid && !seen_error && !line_error;
    assign take_eoc = enable && eoc;
    assign take_err = enable && line_error;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_valid <= 1'b0;
            byte_bits  <= 4'd0;
            byte_last  <= 1'b0;
            frame_end  <= 1'b0;
            seen_error <= 1'b0;
            bit_cnt    <= 3'd0;
        end else begin
            // strobes last a single cycle
            byte_valid <= 1'b0;
            frame_end  <= 1'b0;

            // sticky until the next frame starts
            if (take_err) begin
                seen_error <= 1'b1;
            end

            if (soc) begin
                bit_cnt    <= 3'd0;
                seen_error <= 1'b0;
            end

            if (take_bit) begin
                bit_cnt <= bit_cnt + 3'd1;
                // eighth bit completes the byte
                if (bit_cnt == 3'd7) begin
                    byte_valid <= 1'b1;
                    byte_bits  <= 4'd8;
                    byte_last  <= 1'b0;
                end
            end

            // eoc never coincides with a bit, so the count here is final
            if (take_eoc) begin
                bit_cnt   <= 3'd0;
                frame_end <= 1'b1;
                if ((bit_cnt != 3'd0) && !seen_error && !line_error) begin
                    byte_valid <= 1'b1;
                    byte_bits  <= {1'b0, bit_cnt};
                    byte_last  <= 1'b1;
                end
            end
        end
    end

    // first bit of a byte clears the upper bits, so a partial byte reads as zero-padded
    always_ff @(posedge clk) begin
        if (take_bit) begin
            if (bit_cnt == 3'd0) begin
                byte_data <= {7'd0, bit_data};
            end else begin
                byte_data[bit_cnt] <= bit_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/crc_a_checker.sv
// running CRC_A over the whole bytes of a frame
// residue_zero is high when the frame ended with its correct CRC
`default_nettype none

module crc_a_checker
    import rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic [3:0] byte_bits,
    output logic       residue_zero
);

    logic [15:0] crc_reg;

    // one byte through the reflected register, lsb first
    function automatic logic [15:0] crc_fold(input logic [15:0] crc_in,
                                             input logic [7:0]  data);
        logic [15:0] crc;
        crc = crc_in ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ crc_a_poly;
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_reg <= crc_a_init;
        end else if (clear) begin
            // new frame
            crc_reg <= crc_a_init;
        end else if (byte_valid && (byte_bits == 4'd8)) begin
            // partial bytes never take part in the check
            crc_reg <= crc_fold(crc_reg, byte_data);
        end
    end

    // data followed by its own CRC, low byte first, folds to zero
    assign residue_zero = (crc_reg == 16'h0000);

endmodule

`default_nettype wire

// File: src/rx_byte_fifo.sv
// circular buffer of received bytes with their bit counts
// pointers carry one wrap bit to tell full from empty
`default_nettype none

module rx_byte_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic [3:0] push_bits,
    input  logic       pop,
    output logic [7:0] head_data,
    output logic [3:0] head_bits,
    output logic       empty,
    output logic       full
);

    localparam int addr_w = $clog2(fifo_depth);

    // entry is {bits, data}
    logic [11:0]     mem [0:fifo_depth-1];
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] rd_ptr;
    logic            do_push;
    logic            do_pop;

    // same slot, different lap
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    // overrun and underrun are ignored here as well
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[addr_w-1:0]] <= {push_bits, push_data};
        end
    end

    // head shows the oldest entry, valid only when not empty
    assign {head_bits, head_data} = mem[rd_ptr[addr_w-1:0]];

endmodule

`default_nettype wire

// File: src/rx_frame_ctrl.sv
// frame controller: tracks one frame from soc to frame_end, settles its status,
// then hands the buffered bytes out over the four-phase req/ack port
`default_nettype none

module rx_frame_ctrl
    import rx_pkg::*;
#(
    parameter int fifo_depth = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          soc,
    input  logic          frame_end,
    input  logic          byte_valid,
    input  logic [3:0]    byte_bits,
    input  logic          seen_error,
    input  logic          residue_zero,
    input  logic          fifo_empty,
    input  logic          fifo_full,
    input  logic [7:0]    head_data,
    input  logic [3:0]    head_bits,
    input  logic          out_ack,
    output logic          enable,
    output logic          crc_clear,
    output logic          fifo_push,
    output logic          fifo_pop,
    output logic          out_req,
    output logic [7:0]    out_data,
    output logic [3:0]    out_bits,
    output logic          out_last,
    output frame_status_e out_status
);

    localparam int cnt_w = $clog2(fifo_depth) + 1;

    ctrl_state_e      state;
    // entries of this frame not yet popped
    logic [cnt_w-1:0] pend_cnt;
    // whole bytes, saturating at 3
    logic [1:0]       whole_cnt;
    logic             partial_seen;
    logic             overflow_seen;
    frame_status_e    status_r;
    frame_status_e    status_nxt;
    logic             in_receive;
    logic             part_now;
    logic             ovf_now;
    logic             head_ready;
    logic             take_head;
    logic             drop_req;

    assign in_receive = (state == st_receive);
    assign enable     = in_receive;
    assign crc_clear  = (state == st_idle) && soc;

    // a full FIFO drops the byte and spoils the frame
    assign fifo_push = in_receive && byte_valid && !fifo_full;
    assign ovf_now   = in_receive && byte_valid && fifo_full;
    assign part_now  = in_receive && byte_valid && (byte_bits != 4'd8);

    // line errors win over everything, then frames too short or ragged for a CRC
    always_comb begin
        if (seen_error || overflow_seen || ovf_now) begin
            status_nxt = frame_line_err;
        end else if ((whole_cnt != 2'd3) || partial_seen || part_now) begin
            status_nxt = frame_no_crc;
        end else if (residue_zero) begin
            status_nxt = frame_ok;
        end else begin
            status_nxt = frame_crc_err;
        end
    end

    // empty frame still owes one zero-bit transfer
    assign head_ready = (pend_cnt == '0) || !fifo_empty;
    // wait out a pending pop so the head is current
    assign take_head  = (state == st_deliver) && !out_req && !out_ack && !fifo_pop &&
                        head_ready;
    assign drop_req   = out_req && out_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            pend_cnt      <= '0;
            whole_cnt     <= 2'd0;
            partial_seen  <= 1'b0;
            overflow_seen <= 1'b0;
            status_r      <= frame_no_crc;
            out_req       <= 1'b0;
            out_last      <= 1'b0;
            fifo_pop      <= 1'b0;
        end else begin
            fifo_pop <= 1'b0;

            // pushes only in st_receive, pops only after it
            if (crc_clear) begin
                pend_cnt <= '0;
            end else if (fifo_push) begin
                pend_cnt <= pend_cnt + 1'b1;
            end else if (fifo_pop) begin
                pend_cnt <= pend_cnt - 1'b1;
            end

            case (state)
                st_idle: begin
                    if (soc) begin
                        state         <= st_receive;
                        whole_cnt     <= 2'd0;
                        partial_seen  <= 1'b0;
                        overflow_seen <= 1'b0;
                    end
                end
                st_receive: begin
                    if (byte_valid && (byte_bits == 4'd8) && (whole_cnt != 2'd3)) begin
                        whole_cnt <= whole_cnt + 2'd1;
                    end
                    if (part_now) begin
                        partial_seen <= 1'b1;
                    end
                    if (ovf_now) begin
                        overflow_seen <= 1'b1;
                    end
                    // partial byte and overflow of this cycle are folded into status_nxt
                    if (frame_end) begin
                        status_r <= status_nxt;
                        state    <= st_deliver;
                    end
                end
                st_deliver: begin
                    if (take_head) begin
                        out_req  <= 1'b1;
                        out_last <= (pend_cnt < cnt_w'(2));
                    end
                    // phase 3: drop req, pop the entry just taken
                    if (drop_req) begin
                        out_req  <= 1'b0;
                        fifo_pop <= (pend_cnt != '0);
                        if (out_last) begin
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload latched as req rises and held through the handshake
    always_ff @(posedge clk) begin
        if (take_head) begin
            out_data <= (pend_cnt == '0) ? 8'h00 : head_data;
            out_bits <= (pend_cnt == '0) ? 4'd0 : head_bits;
        end
    end

    // constant for the whole delivery
    assign out_status = status_r;

endmodule

`default_nettype wire

// File: src/rx_pkg.sv
// shared types and constants for the type A receive path
// imported by the frame controller, the CRC checker and the top level
`default_nettype none

package rx_pkg;

    // outcome of one received frame, reported with the last byte
    typedef enum logic [1:0] {
        frame_ok       = 2'd0,
        frame_no_crc   = 2'd1,
        frame_crc_err  = 2'd2,
        frame_line_err = 2'd3
    } frame_status_e;

    // frame controller states
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_receive = 2'd1,
        st_deliver = 2'd2
    } ctrl_state_e;

    // CRC_A start value and reflected form of x^16 + x^12 + x^5 + 1
    localparam logic [15:0] crc_a_init = 16'h6363;
    localparam logic [15:0] crc_a_poly = 16'h8408;

endpackage

`default_nettype wire

// File: src/rx_top.sv
// receive path top level: deserialiser, CRC_A check, byte FIFO and frame controller
// fifo_depth sets the buffered bytes per frame, a power of two
`default_nettype none

module rx_top
    import rx_pkg::*;
#(
    parameter int fifo_depth = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          soc,
    input  logic          eoc,
    input  logic          bit_valid,
    input  logic          bit_data,
    input  logic          line_error,
    input  logic          out_ack,
    output logic          out_req,
    output logic [7:0]    out_data,
    output logic [3:0]    out_bits,
    output logic          out_last,
    output frame_status_e out_status
);

    logic       enable;
    logic       byte_valid;
    logic [7:0] byte_data;
    logic [3:0] byte_bits;
    logic       frame_end;
    logic       seen_error;
    logic       crc_clear;
    logic       residue_zero;
    logic       fifo_push;
    logic       fifo_pop;
    logic       fifo_empty;
    logic       fifo_full;
    logic [7:0] head_data;
    logic [3:0] head_bits;

    // partial bytes are recognised by byte_bits, so the last marker stays open
    bit_deserialiser deser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .soc        (soc),
        .eoc        (eoc),
        .bit_valid  (bit_valid),
        .bit_data   (bit_data),
        .line_error (line_error),
        .enable     (enable),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_bits  (byte_bits),
        .byte_last  (),
        .frame_end  (frame_end),
        .seen_error (seen_error)
    );

    crc_a_checker crc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (crc_clear),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .byte_bits    (byte_bits),
        .residue_zero (residue_zero)
    );

    rx_byte_fifo #(
        .fifo_depth (fifo_depth)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fifo_push),
        .push_data (byte_data),
        .push_bits (byte_bits),
        .pop       (fifo_pop),
        .head_data (head_data),
        .head_bits (head_bits),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    rx_frame_ctrl #(
        .fifo_depth (fifo_depth)
    ) ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .soc          (soc),
        .frame_end    (frame_end),
        .byte_valid   (byte_valid),
        .byte_bits    (byte_bits),
        .seen_error   (seen_error),
        .residue_zero (residue_zero),
        .fifo_empty   (fifo_empty),
        .fifo_full    (fifo_full),
        .head_data    (head_data),
        .head_bits    (head_bits),
        .out_ack      (out_ack),
        .enable       (enable),
        .crc_clear    (crc_clear),
        .fifo_push    (fifo_push),
        .fifo_pop     (fifo_pop),
        .out_req      (out_req),
        .out_data     (out_data),
        .out_bits     (out_bits),
        .out_last     (out_last),
        .out_status   (out_status)
    );

endmodule

`default_nettype wire
